// File: Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/ooo_pkg.sv
      - hdl/ooo_ifs.sv
      - hdl/dispatch_unit.sv
      - hdl/register_file.sv
      - hdl/reorder_buffer.sv
      - hdl/alu_station.sv
      - hdl/ooo_core.sv
  - target: test
    files:
      - sim/ooo_core_tb.sv

// File: hdl/alu_station.sv
`default_nettype none

`include "ooo_config.svh"

module alu_station (
   input  wire              clk,
   input  wire              i_rst,
   dispatch_if.station      dsp,
   output logic             o_cdb_valid,
   output ooo_pkg::tag_t    o_cdb_tag,
   output ooo_pkg::data_t   o_cdb_data
);

   localparam int DEPTH = `OOO_RS_DEPTH;
   localparam int IDX_W = $clog2(DEPTH);

   logic [DEPTH-1:0]  valid;
   ooo_pkg::opcode_t  op     [DEPTH];
   ooo_pkg::tag_t     tag    [DEPTH];
   ooo_pkg::data_t    val_a  [DEPTH];
   ooo_pkg::data_t    val_b  [DEPTH];
   logic [DEPTH-1:0]  rdy_a;
   logic [DEPTH-1:0]  rdy_b;
   ooo_pkg::tag_t     wait_a [DEPTH];
   ooo_pkg::tag_t     wait_b [DEPTH];
   // Zero is the oldest live entry
   logic [IDX_W-1:0]  age    [DEPTH];

   logic              sel_valid;
   logic [IDX_W-1:0]  sel;
   logic [IDX_W-1:0]  wr_idx;
   logic [IDX_W:0]    n_valid;
   ooo_pkg::data_t    result;

   assign dsp.full = &valid;

   always_comb begin
      sel_valid = 1'b0;
      sel       = '0;
      wr_idx    = '0;
      n_valid   = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (!valid[i]) begin
            wr_idx = IDX_W'(i);
         end
      end
      for (int i = 0; i < DEPTH; i++) begin
         n_valid = n_valid + valid[i];
         if (valid[i] && rdy_a[i] && rdy_b[i] && (!sel_valid || age[i] < age[sel])) begin
            sel_valid = 1'b1;
            sel       = IDX_W'(i);
         end
      end
   end

   always_comb begin
      case (op[sel])
         ooo_pkg::OP_ADD, ooo_pkg::OP_ADDI: result = val_a[sel] + val_b[sel];
         ooo_pkg::OP_SUB, ooo_pkg::OP_SUBI: result = val_a[sel] - val_b[sel];
         ooo_pkg::OP_AND:                   result = val_a[sel] & val_b[sel];
         ooo_pkg::OP_OR:                    result = val_a[sel] | val_b[sel];
         ooo_pkg::OP_XOR:                   result = val_a[sel] ^ val_b[sel];
         ooo_pkg::OP_SETI:                  result = val_b[sel];
         default:                           result = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid       <= '0;
         o_cdb_valid <= 1'b0;
      end else begin
         if (sel_valid) begin
            valid[sel] <= 1'b0;
         end
         if (dsp.valid) begin
            valid[wr_idx] <= 1'b1;
         end
         o_cdb_valid <= sel_valid;
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         // Snoop our own bus output for waiting operands
         if (o_cdb_valid && valid[i] && !rdy_a[i] && wait_a[i] == o_cdb_tag) begin
            val_a[i] <= o_cdb_data;
            rdy_a[i] <= 1'b1;
         end
         if (o_cdb_valid && valid[i] && !rdy_b[i] && wait_b[i] == o_cdb_tag) begin
            val_b[i] <= o_cdb_data;
            rdy_b[i] <= 1'b1;
         end
         if (sel_valid && valid[i] && age[i] > age[sel]) begin
            age[i] <= age[i] - 1'b1;
         end
      end
      if (dsp.valid) begin
         op[wr_idx]     <= dsp.op;
         tag[wr_idx]    <= dsp.tag;
         val_a[wr_idx]  <= dsp.value_a;
         val_b[wr_idx]  <= dsp.value_b;
         rdy_a[wr_idx]  <= dsp.ready_a;
         rdy_b[wr_idx]  <= dsp.ready_b;
         wait_a[wr_idx] <= dsp.wait_tag_a;
         wait_b[wr_idx] <= dsp.wait_tag_b;
         age[wr_idx]    <= IDX_W'(n_valid - sel_valid);
      end
      o_cdb_tag  <= tag[sel];
      o_cdb_data <= result;
   end

   a_no_write_when_full: assert property (
      @(posedge clk) disable iff (i_rst) dsp.valid |-> !dsp.full);

endmodule

`default_nettype wire

// File: hdl/dispatch_unit.sv
`default_nettype none

module dispatch_unit (
   input  wire                     clk,
   input  wire                     i_rst,
   input  wire                     i_instr_valid,
   input  wire ooo_pkg::instr_t    i_instr,
   output logic                    o_instr_ready,
   output logic                    o_rsv_valid,
   output ooo_pkg::reg_addr_t      o_rsv_dst,
   output ooo_pkg::tag_t           o_rsv_tag,
   output ooo_pkg::reg_addr_t      o_rd_addr_a,
   output ooo_pkg::reg_addr_t      o_rd_addr_b,
   input  wire ooo_pkg::data_t     i_rd_value_a,
   input  wire ooo_pkg::data_t     i_rd_value_b,
   input  wire                     i_rd_busy_a,
   input  wire                     i_rd_busy_b,
   input  wire ooo_pkg::tag_t      i_rd_tag_a,
   input  wire ooo_pkg::tag_t      i_rd_tag_b,
   input  wire                     i_cdb_valid,
   input  wire ooo_pkg::tag_t      i_cdb_tag,
   input  wire ooo_pkg::data_t     i_cdb_data,
   rob_lookup_if.dispatcher        lookup,
   dispatch_if.source              dsp
);

   ooo_pkg::opcode_t op;
   ooo_pkg::data_t   src_a;
   ooo_pkg::data_t   src_b;
   logic             src_a_ok;
   logic             src_b_ok;
   logic             run_q;
   logic             accept;

   // Register file, then a finished ROB entry, then this cycle's bus result
   function automatic void pick_operand(
      input  ooo_pkg::data_t reg_value,
      input  logic           busy,
      input  ooo_pkg::tag_t  tag,
      input  ooo_pkg::data_t rob_data,
      input  logic           rob_done,
      output ooo_pkg::data_t value,
      output logic           ready
   );
      value = reg_value;
      ready = 1'b1;
      if (busy) begin
         if (rob_done) begin
            value = rob_data;
         end else if (i_cdb_valid && i_cdb_tag == tag) begin
            value = i_cdb_data;
         end else begin
            ready = 1'b0;
         end
      end
   endfunction

   // Holds the input off until the cycle after reset
   always_ff @(posedge clk) begin
      if (i_rst) begin
         run_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
      end
   end

   assign op            = ooo_pkg::opcode_t'(i_instr[31:26]);
   assign o_rd_addr_a   = i_instr[19:16];
   assign o_rd_addr_b   = i_instr[15:12];
   assign lookup.tag_a  = i_rd_tag_a;
   assign lookup.tag_b  = i_rd_tag_b;

   assign o_instr_ready = run_q && !lookup.full && !dsp.full;
   assign accept        = i_instr_valid && o_instr_ready;

   // NOP is consumed here and reserves nothing
   assign o_rsv_valid   = accept && op != ooo_pkg::OP_NOP;
   assign o_rsv_dst     = i_instr[23:20];
   assign o_rsv_tag     = lookup.free_tag;

   assign dsp.valid      = o_rsv_valid;
   assign dsp.tag        = lookup.free_tag;
   assign dsp.op         = op;
   assign dsp.wait_tag_a = i_rd_tag_a;
   assign dsp.wait_tag_b = i_rd_tag_b;

   always_comb begin
      pick_operand(i_rd_value_a, i_rd_busy_a, i_rd_tag_a, lookup.data_a, lookup.done_a,
                   src_a, src_a_ok);
      pick_operand(i_rd_value_b, i_rd_busy_b, i_rd_tag_b, lookup.data_b, lookup.done_b,
                   src_b, src_b_ok);
   end

   always_comb begin
      dsp.value_a = src_a;
      dsp.ready_a = src_a_ok;
      dsp.value_b = src_b;
      dsp.ready_b = src_b_ok;
      case (op)
         ooo_pkg::OP_ADDI, ooo_pkg::OP_SUBI: begin
            dsp.value_b = ooo_pkg::data_t'(signed'(i_instr[15:0]));
            dsp.ready_b = 1'b1;
         end
         ooo_pkg::OP_SETI: begin
            // No register source at all
            dsp.value_b = ooo_pkg::data_t'(i_instr[15:0]);
            dsp.ready_a = 1'b1;
            dsp.ready_b = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // A waiting operand names a slot in flight, never the one being allocated
   a_wait_tag_in_flight: assert property (
      @(posedge clk) disable iff (i_rst)
      dsp.valid |-> (dsp.ready_a || dsp.wait_tag_a != dsp.tag) &&
                    (dsp.ready_b || dsp.wait_tag_b != dsp.tag));

endmodule

`default_nettype wire

// File: hdl/ooo_core.sv
`default_nettype none

module ooo_core (
   input  wire                     clk,
   input  wire                     i_rst,
   input  wire                     i_instr_valid,
   input  wire ooo_pkg::instr_t    i_instr,
   output logic                    o_instr_ready,
   output logic                    o_commit_valid,
   output ooo_pkg::reg_addr_t      o_commit_reg,
   output ooo_pkg::data_t          o_commit_data
);

   logic               rsv_valid;
   ooo_pkg::reg_addr_t rsv_dst;
   ooo_pkg::tag_t      rsv_tag;

   ooo_pkg::reg_addr_t rd_addr_a;
   ooo_pkg::reg_addr_t rd_addr_b;
   ooo_pkg::data_t     rd_value_a;
   ooo_pkg::data_t     rd_value_b;
   logic               rd_busy_a;
   logic               rd_busy_b;
   ooo_pkg::tag_t      rd_tag_a;
   ooo_pkg::tag_t      rd_tag_b;

   // Common data bus, single producer
   logic               cdb_valid;
   ooo_pkg::tag_t      cdb_tag;
   ooo_pkg::data_t     cdb_data;

   dispatch_if   dsp ();
   commit_if     cmt ();
   rob_lookup_if lkp ();

   assign o_commit_valid = cmt.valid;
   assign o_commit_reg   = cmt.dst;
   assign o_commit_data  = cmt.data;

   dispatch_unit dispatch_inst (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_instr_valid (i_instr_valid),
      .i_instr       (i_instr),
      .o_instr_ready (o_instr_ready),
      .o_rsv_valid   (rsv_valid),
      .o_rsv_dst     (rsv_dst),
      .o_rsv_tag     (rsv_tag),
      .o_rd_addr_a   (rd_addr_a),
      .o_rd_addr_b   (rd_addr_b),
      .i_rd_value_a  (rd_value_a),
      .i_rd_value_b  (rd_value_b),
      .i_rd_busy_a   (rd_busy_a),
      .i_rd_busy_b   (rd_busy_b),
      .i_rd_tag_a    (rd_tag_a),
      .i_rd_tag_b    (rd_tag_b),
      .i_cdb_valid   (cdb_valid),
      .i_cdb_tag     (cdb_tag),
      .i_cdb_data    (cdb_data),
      .lookup        (lkp),
      .dsp           (dsp)
   );

   register_file reg_inst (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_rsv_valid  (rsv_valid),
      .i_rsv_dst    (rsv_dst),
      .i_rsv_tag    (rsv_tag),
      .i_rd_addr_a  (rd_addr_a),
      .i_rd_addr_b  (rd_addr_b),
      .o_rd_value_a (rd_value_a),
      .o_rd_value_b (rd_value_b),
      .o_rd_busy_a  (rd_busy_a),
      .o_rd_busy_b  (rd_busy_b),
      .o_rd_tag_a   (rd_tag_a),
      .o_rd_tag_b   (rd_tag_b),
      .commit       (cmt)
   );

   // Allocation rides on the register reservation
   reorder_buffer rob_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_alloc     (rsv_valid),
      .i_alloc_dst (rsv_dst),
      .i_cdb_valid (cdb_valid),
      .i_cdb_tag   (cdb_tag),
      .i_cdb_data  (cdb_data),
      .lookup      (lkp),
      .commit      (cmt)
   );

   alu_station alu_inst (
      .clk        (clk),
      .i_rst      (i_rst),
      .dsp        (dsp),
      .o_cdb_valid(cdb_valid),
      .o_cdb_tag  (cdb_tag),
      .o_cdb_data (cdb_data)
   );

endmodule

`default_nettype wire

// File: hdl/ooo_ifs.sv
`default_nettype none

// New entry for the reservation station
interface dispatch_if;
   logic             valid;
   ooo_pkg::tag_t    tag;
   ooo_pkg::opcode_t op;
   ooo_pkg::data_t   value_a;
   ooo_pkg::data_t   value_b;
   logic             ready_a;
   logic             ready_b;
   ooo_pkg::tag_t    wait_tag_a;
   ooo_pkg::tag_t    wait_tag_b;
   logic             full;

   modport source (output valid, tag, op, value_a, value_b, ready_a, ready_b,
                   output wait_tag_a, wait_tag_b, input full);
   modport station (input valid, tag, op, value_a, value_b, ready_a, ready_b,
                    input wait_tag_a, wait_tag_b, output full);
endinterface

// In-order register write from the reorder buffer
interface commit_if;
   logic               valid;
   ooo_pkg::tag_t      tag;
   ooo_pkg::reg_addr_t dst;
   ooo_pkg::data_t     data;

   modport source (output valid, tag, dst, data);
   modport sink (input valid, tag, dst, data);
endinterface

// Operand lookup and slot allocation
interface rob_lookup_if;
   ooo_pkg::tag_t  tag_a;
   ooo_pkg::tag_t  tag_b;
   ooo_pkg::data_t data_a;
   ooo_pkg::data_t data_b;
   logic           done_a;
   logic           done_b;
   ooo_pkg::tag_t  free_tag;
   logic           full;

   modport dispatcher (output tag_a, tag_b, input data_a, data_b, done_a, done_b,
                       input free_tag, full);
   modport buffer (input tag_a, tag_b, output data_a, data_b, done_a, done_b,
                   output free_tag, full);
endinterface

`default_nettype wire

// File: hdl/ooo_pkg.sv
`default_nettype none

`include "ooo_config.svh"

package ooo_pkg;

   // Opcode field, instruction bits 31:26
   typedef enum logic [5:0] {
      OP_NOP  = 6'd0,
      OP_ADD  = 6'd1,
      OP_SUB  = 6'd2,
      OP_AND  = 6'd3,
      OP_OR   = 6'd4,
      OP_XOR  = 6'd5,
      OP_ADDI = 6'd6,
      OP_SUBI = 6'd7,
      OP_SETI = 6'd8
   } opcode_t;

   typedef logic [`OOO_DATA_W-1:0]     data_t;
   typedef logic [`OOO_INSTR_W-1:0]    instr_t;
   typedef logic [`OOO_REG_ADDR_W-1:0] reg_addr_t;

   // Reorder-buffer slot, doubles as the rename tag
   typedef logic [`OOO_TAG_W-1:0]      tag_t;

endpackage

`default_nettype wire

// File: hdl/register_file.sv
`default_nettype none

`include "ooo_config.svh"

module register_file (
   input  wire                     clk,
   input  wire                     i_rst,
   input  wire                     i_rsv_valid,
   input  wire ooo_pkg::reg_addr_t i_rsv_dst,
   input  wire ooo_pkg::tag_t      i_rsv_tag,
   input  wire ooo_pkg::reg_addr_t i_rd_addr_a,
   input  wire ooo_pkg::reg_addr_t i_rd_addr_b,
   output ooo_pkg::data_t          o_rd_value_a,
   output ooo_pkg::data_t          o_rd_value_b,
   output logic                    o_rd_busy_a,
   output logic                    o_rd_busy_b,
   output ooo_pkg::tag_t           o_rd_tag_a,
   output ooo_pkg::tag_t           o_rd_tag_b,
   commit_if.sink                  commit
);

   localparam int N_REGS = 2 ** `OOO_REG_ADDR_W;

   ooo_pkg::data_t    value [N_REGS];
   ooo_pkg::tag_t     tag   [N_REGS];
   logic [N_REGS-1:0] busy;

   assign o_rd_value_a = value[i_rd_addr_a];
   assign o_rd_value_b = value[i_rd_addr_b];
   assign o_rd_busy_a  = busy[i_rd_addr_a];
   assign o_rd_busy_b  = busy[i_rd_addr_b];
   assign o_rd_tag_a   = tag[i_rd_addr_a];
   assign o_rd_tag_b   = tag[i_rd_addr_b];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         busy <= '0;
         for (int i = 0; i < N_REGS; i++) begin
            value[i] <= '0;
         end
      end else begin
         if (commit.valid) begin
            value[commit.dst] <= commit.data;
            // A younger rename keeps the register busy
            if (tag[commit.dst] == commit.tag) begin
               busy[commit.dst] <= 1'b0;
            end
         end
         if (i_rsv_valid) begin
            busy[i_rsv_dst] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rsv_valid) begin
         tag[i_rsv_dst] <= i_rsv_tag;
      end
   end

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`default_nettype none

`include "ooo_config.svh"

module reorder_buffer (
   input  wire                     clk,
   input  wire                     i_rst,
   input  wire                     i_alloc,
   input  wire ooo_pkg::reg_addr_t i_alloc_dst,
   input  wire                     i_cdb_valid,
   input  wire ooo_pkg::tag_t      i_cdb_tag,
   input  wire ooo_pkg::data_t     i_cdb_data,
   rob_lookup_if.buffer            lookup,
   commit_if.source                commit
);

   localparam int DEPTH = `OOO_ROB_DEPTH;

   logic [DEPTH-1:0]       valid;
   logic [DEPTH-1:0]       done;
   ooo_pkg::reg_addr_t     dst  [DEPTH];
   ooo_pkg::data_t         data [DEPTH];

   ooo_pkg::tag_t          head;
   ooo_pkg::tag_t          tail;
   logic [`OOO_TAG_W:0]    count;
   logic                   retire;

   assign retire = valid[head] && done[head];

   assign lookup.free_tag = tail;
   assign lookup.full     = count == (`OOO_TAG_W + 1)'(DEPTH);
   assign lookup.data_a   = data[lookup.tag_a];
   assign lookup.data_b   = data[lookup.tag_b];
   assign lookup.done_a   = valid[lookup.tag_a] && done[lookup.tag_a];
   assign lookup.done_b   = valid[lookup.tag_b] && done[lookup.tag_b];

   // Head commits the cycle after it is marked done
   assign commit.valid = retire;
   assign commit.tag   = head;
   assign commit.dst   = dst[head];
   assign commit.data  = data[head];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         valid <= '0;
         done  <= '0;
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (i_alloc) begin
            valid[tail] <= 1'b1;
            done[tail]  <= 1'b0;
            tail        <= tail + 1'b1;
         end
         if (i_cdb_valid) begin
            done[i_cdb_tag] <= 1'b1;
         end
         if (retire) begin
            valid[head] <= 1'b0;
            head        <= head + 1'b1;
         end
         case ({i_alloc, retire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_alloc) begin
         dst[tail] <= i_alloc_dst;
      end
      if (i_cdb_valid) begin
         data[i_cdb_tag] <= i_cdb_data;
      end
   end

   a_no_alloc_when_full: assert property (
      @(posedge clk) disable iff (i_rst) i_alloc |-> !lookup.full);

   // Every broadcast result belongs to a live slot still in flight
   a_cdb_hits_pending: assert property (
      @(posedge clk) disable iff (i_rst) i_cdb_valid |-> valid[i_cdb_tag] && !done[i_cdb_tag]);

endmodule

`default_nettype wire

// File: include/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// Datapath widths
`define OOO_DATA_W     32
`define OOO_INSTR_W    32

// 16 architectural registers
`define OOO_REG_ADDR_W 4

// Rename tags index the reorder buffer, so TAG_W is log2 of its depth
`define OOO_ROB_DEPTH  8
`define OOO_TAG_W      3

// ALU reservation station entries
`define OOO_RS_DEPTH   4

`endif

// File: ooo_core.f
+incdir+include
hdl/ooo_pkg.sv
hdl/ooo_ifs.sv
hdl/dispatch_unit.sv
hdl/register_file.sv
hdl/reorder_buffer.sv
hdl/alu_station.sv
hdl/ooo_core.sv
sim/ooo_core_tb.sv

// File: sim/ooo_core_tb.sv
`default_nettype none

module ooo_core_tb;

   logic               clk = 1'b0;
   logic               i_rst;
   logic               i_instr_valid;
   ooo_pkg::instr_t    i_instr;
   logic               o_instr_ready;
   logic               o_commit_valid;
   ooo_pkg::reg_addr_t o_commit_reg;
   ooo_pkg::data_t     o_commit_data;

   // Stimulus table with the idle gap after each entry
   // A gap of -1 picks a random gap of 0 to 3 cycles
   ooo_pkg::instr_t    stim_instr [$];
   int                 stim_gap   [$];

   // Reference registers and the commits still expected, in program order
   ooo_pkg::data_t     ref_regs [16];
   ooo_pkg::reg_addr_t exp_reg  [$];
   ooo_pkg::data_t     exp_data [$];

   integer             seed = 32'he81d_81e4;
   int                 errors = 0;
   int                 checks = 0;
   int                 commits = 0;
   int                 expected_commits = 0;
   int                 stall_cycles = 0;
   int                 cycle_count = 0;
   int                 cycle_limit = 0;
   int                 gap;

   always #5 clk = ~clk;

   ooo_core dut (
      .clk            (clk),
      .i_rst          (i_rst),
      .i_instr_valid  (i_instr_valid),
      .i_instr        (i_instr),
      .o_instr_ready  (o_instr_ready),
      .o_commit_valid (o_commit_valid),
      .o_commit_reg   (o_commit_reg),
      .o_commit_data  (o_commit_data)
   );

   function automatic ooo_pkg::instr_t encode_reg(ooo_pkg::opcode_t op, int dst, int a, int b);
      return {op, 2'b00, 4'(dst), 4'(a), 4'(b), 12'h000};
   endfunction

   function automatic ooo_pkg::instr_t encode_imm(ooo_pkg::opcode_t op, int dst, int a,
                                                  logic [15:0] imm);
      return {op, 2'b00, 4'(dst), 4'(a), imm};
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, expected, $time);
      end
   endtask

   task automatic add_entry(input ooo_pkg::instr_t w, input int gap_cycles);
      stim_instr.push_back(w);
      stim_gap.push_back(gap_cycles);
   endtask

   task automatic load_table();
      // Every opcode alone, with negative immediates and wrap-around
      add_entry(encode_imm(ooo_pkg::OP_SETI, 1, 0, 16'h1234), -1);
      add_entry(encode_imm(ooo_pkg::OP_SETI, 2, 0, 16'hffff), -1);
      add_entry(encode_imm(ooo_pkg::OP_ADDI, 3, 1, 16'h8000), -1);
      add_entry(encode_imm(ooo_pkg::OP_SUBI, 4, 2, 16'hffff), -1);
      add_entry(encode_reg(ooo_pkg::OP_ADD, 5, 1, 2), -1);
      add_entry(encode_reg(ooo_pkg::OP_SUB, 6, 1, 2), -1);
      add_entry(encode_reg(ooo_pkg::OP_AND, 7, 3, 2), -1);
      add_entry(encode_reg(ooo_pkg::OP_OR, 8, 1, 4), -1);
      add_entry(encode_reg(ooo_pkg::OP_XOR, 9, 3, 5), -1);
      add_entry(encode_imm(ooo_pkg::OP_SUBI, 10, 0, 16'h0001), -1);
      add_entry(encode_imm(ooo_pkg::OP_ADDI, 10, 10, 16'h0002), -1);
      add_entry(encode_reg(ooo_pkg::OP_NOP, 11, 1, 2), -1);
      // One cycle apart puts the producer on the bus at dispatch
      add_entry(encode_imm(ooo_pkg::OP_SETI, 11, 0, 16'h0042), 1);
      add_entry(encode_imm(ooo_pkg::OP_ADDI, 11, 11, 16'hfffe), -1);
      // Back-to-back chain waits on tags still in flight
      add_entry(encode_imm(ooo_pkg::OP_ADDI, 12, 1, 16'h0005), 0);
      add_entry(encode_reg(ooo_pkg::OP_ADD, 13, 12, 12), 0);
      add_entry(encode_reg(ooo_pkg::OP_SUB, 14, 13, 1), 0);
      add_entry(encode_reg(ooo_pkg::OP_XOR, 12, 14, 13), -1);
      // Younger SETI finishes ahead of the dependent pair
      add_entry(encode_reg(ooo_pkg::OP_ADD, 1, 12, 3), 0);
      add_entry(encode_reg(ooo_pkg::OP_ADD, 2, 1, 1), 0);
      add_entry(encode_imm(ooo_pkg::OP_SETI, 15, 0, 16'haaaa), 0);
      add_entry(encode_reg(ooo_pkg::OP_OR, 0, 15, 2), -1);
      // Long dependent burst that fills the station and the ROB
      for (int i = 0; i < 12; i++) begin
         add_entry(encode_imm(ooo_pkg::OP_ADDI, 5, 5, 16'(i * 37 + 3)), 0);
         add_entry(encode_reg(ooo_pkg::OP_ADD, 6, 6, 5), 0);
         if (i % 4 == 3) begin
            add_entry(encode_reg(ooo_pkg::OP_NOP, 6, 0, 0), 0);
         end
      end
      add_entry(encode_reg(ooo_pkg::OP_SUB, 7, 6, 5), -1);
      add_entry(encode_reg(ooo_pkg::OP_AND, 8, 6, 15), -1);
      add_entry(encode_imm(ooo_pkg::OP_SUBI, 9, 6, 16'h8001), -1);
   endtask

   task automatic model_step(input ooo_pkg::instr_t w);
      ooo_pkg::opcode_t   op;
      ooo_pkg::reg_addr_t dst;
      ooo_pkg::data_t     a;
      ooo_pkg::data_t     b;
      ooo_pkg::data_t     imm_s;
      ooo_pkg::data_t     imm_z;
      ooo_pkg::data_t     res;
      op    = ooo_pkg::opcode_t'(w[31:26]);
      dst   = w[23:20];
      a     = ref_regs[w[19:16]];
      b     = ref_regs[w[15:12]];
      imm_s = {{16{w[15]}}, w[15:0]};
      imm_z = {16'h0000, w[15:0]};
      case (op)
         ooo_pkg::OP_ADD:  res = a + b;
         ooo_pkg::OP_SUB:  res = a - b;
         ooo_pkg::OP_AND:  res = a & b;
         ooo_pkg::OP_OR:   res = a | b;
         ooo_pkg::OP_XOR:  res = a ^ b;
         ooo_pkg::OP_ADDI: res = a + imm_s;
         ooo_pkg::OP_SUBI: res = a - imm_s;
         ooo_pkg::OP_SETI: res = imm_z;
         default:          res = '0;
      endcase
      if (op != ooo_pkg::OP_NOP) begin
         ref_regs[dst] = res;
         exp_reg.push_back(dst);
         exp_data.push_back(res);
         expected_commits++;
      end
   endtask

   // Entered just after a rising edge, returns just after the accepting edge
   task automatic send(input ooo_pkg::instr_t w);
      i_instr       = w;
      i_instr_valid = 1'b1;
      @(negedge clk);
      while (!o_instr_ready) begin
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      i_instr_valid = 1'b0;
      model_step(w);
   endtask

   task automatic print_counts();
      $display("Checks %0d, errors %0d, commits %0d of %0d expected",
               checks, errors, commits, expected_commits);
   endtask

   always @(negedge clk) begin
      if (i_rst) begin
         check("o_commit_valid", o_commit_valid, 0);
         check("o_instr_ready", o_instr_ready, 0);
      end else begin
         if (i_instr_valid && !o_instr_ready) begin
            stall_cycles++;
         end
         if (o_commit_valid) begin
            commits++;
            if (exp_reg.size() == 0) begin
               errors++;
               $display("Commit to r%0d with no instruction outstanding at %0t",
                        o_commit_reg, $time);
            end else begin
               check("o_commit_reg", o_commit_reg, exp_reg.pop_front());
               check("o_commit_data", o_commit_data, exp_data.pop_front());
            end
         end
      end
   end

   initial begin
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      errors++;
      print_counts();
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      i_rst         = 1'b1;
      i_instr_valid = 1'b0;
      i_instr       = '0;
      foreach (ref_regs[i]) begin
         ref_regs[i] = '0;
      end
      load_table();
      cycle_limit = stim_instr.size() * 8 + 200;
      repeat (4) @(posedge clk);
      #1;
      i_rst = 1'b0;
      // Any commit in these idle cycles is an error
      repeat (5) @(posedge clk);
      #1;
      foreach (stim_instr[i]) begin
         send(stim_instr[i]);
         gap = stim_gap[i];
         if (gap < 0) begin
            gap = $unsigned($random(seed)) % 4;
         end
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
      end
      while (commits < expected_commits) begin
         @(negedge clk);
      end
      repeat (10) @(negedge clk);
      check("pending_commits", exp_reg.size(), 0);
      check("commit_count", commits, expected_commits);
      if (stall_cycles == 0) begin
         errors++;
         $display("o_instr_ready never dropped while an instruction was waiting");
      end
      print_counts();
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
